/* design/dense_layer.sv */
`timescale 1ns/1ps

module dense_layer #(
  parameter int NUM_INPUTS  = nn_layer_pkg::DEFAULT_INPUTS,
  parameter int NUM_NODES   = nn_layer_pkg::DEFAULT_NODES,
  parameter int LEARN_SHIFT = nn_layer_pkg::DEFAULT_LEARN_SHIFT
) (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  train,

  input  logic                                  sample_valid,
  input  nn_format_pkg::act_t [NUM_INPUTS-1:0]  sample_data,
  output logic                                  sample_ready,

  output logic                                  result_valid,
  output nn_format_pkg::act_t [NUM_NODES-1:0]   result_data,
  input  logic                                  result_ready,

  input  logic                                  delta_valid,
  input  nn_format_pkg::grad_t [NUM_NODES-1:0]  delta_data,
  output logic                                  delta_ready,

  output logic                                  error_valid,
  output nn_format_pkg::grad_t [NUM_INPUTS-1:0] error_data,
  input  logic                                  error_ready
);
  import nn_format_pkg::*;

  logic [NUM_NODES-1:0]                 node_sample_valid;
  act_t [NUM_INPUTS-1:0]                node_sample_data;
  logic [NUM_NODES-1:0]                 node_sample_ready;
  logic [NUM_NODES-1:0]                 node_delta_valid;
  grad_t [NUM_NODES-1:0]                node_delta_data;
  logic [NUM_NODES-1:0]                 node_delta_ready;
  logic [NUM_NODES-1:0]                 node_result_valid;
  act_t [NUM_NODES-1:0]                 node_result_data;
  logic [NUM_NODES-1:0]                 node_result_ready;
  logic [NUM_NODES-1:0]                 node_error_valid;
  grad_t [NUM_NODES-1:0][NUM_INPUTS-1:0] node_error_data;
  logic [NUM_NODES-1:0]                 node_error_ready;

  layer_dispatch #(
    .NUM_INPUTS (NUM_INPUTS),
    .NUM_NODES  (NUM_NODES)
  ) u_dispatch (
    .clock             (clock),
    .reset             (reset),
    .sample_valid      (sample_valid),
    .sample_data       (sample_data),
    .sample_ready      (sample_ready),
    .delta_valid       (delta_valid),
    .delta_data        (delta_data),
    .delta_ready       (delta_ready),
    .node_sample_valid (node_sample_valid),
    .node_sample_data  (node_sample_data),
    .node_sample_ready (node_sample_ready),
    .node_delta_valid  (node_delta_valid),
    .node_delta_data   (node_delta_data),
    .node_delta_ready  (node_delta_ready)
  );

  for (genvar n = 0; n < NUM_NODES; n++) begin : gen_node
    neuron_node #(
      .NUM_INPUTS  (NUM_INPUTS),
      .LEARN_SHIFT (LEARN_SHIFT)
    ) u_node (
      .clock        (clock),
      .reset        (reset),
      .train        (train),
      .sample_valid (node_sample_valid[n]),
      .sample_data  (node_sample_data),
      .sample_ready (node_sample_ready[n]),
      .result_valid (node_result_valid[n]),
      .result_data  (node_result_data[n]),
      .result_ready (node_result_ready[n]),
      .delta_valid  (node_delta_valid[n]),
      .delta_data   (node_delta_data[n]),
      .delta_ready  (node_delta_ready[n]),
      .error_valid  (node_error_valid[n]),
      .error_data   (node_error_data[n]),
      .error_ready  (node_error_ready[n])
    );
  end

  layer_gather #(
    .NUM_INPUTS (NUM_INPUTS),
    .NUM_NODES  (NUM_NODES)
  ) u_gather (
    .clock             (clock),
    .reset             (reset),
    .node_result_valid (node_result_valid),
    .node_result_data  (node_result_data),
    .node_result_ready (node_result_ready),
    .node_error_valid  (node_error_valid),
    .node_error_data   (node_error_data),
    .node_error_ready  (node_error_ready),
    .result_valid      (result_valid),
    .result_data       (result_data),
    .result_ready      (result_ready),
    .error_valid       (error_valid),
    .error_data        (error_data),
    .error_ready       (error_ready)
  );

endmodule

/* design/layer_dispatch.sv */
`timescale 1ns/1ps

module layer_dispatch #(
  parameter int NUM_INPUTS = 2,
  parameter int NUM_NODES  = 1
) (
  input  logic                                  clock,
  input  logic                                  reset,

  input  logic                                  sample_valid,
  input  nn_format_pkg::act_t [NUM_INPUTS-1:0]  sample_data,
  output logic                                  sample_ready,

  input  logic                                  delta_valid,
  input  nn_format_pkg::grad_t [NUM_NODES-1:0]  delta_data,
  output logic                                  delta_ready,

  output logic [NUM_NODES-1:0]                  node_sample_valid,
  output nn_format_pkg::act_t [NUM_INPUTS-1:0]  node_sample_data,
  input  logic [NUM_NODES-1:0]                  node_sample_ready,

  output logic [NUM_NODES-1:0]                  node_delta_valid,
  output nn_format_pkg::grad_t [NUM_NODES-1:0]  node_delta_data,
  input  logic [NUM_NODES-1:0]                  node_delta_ready
);

  // One bit per node that has not yet taken the held item
  logic [NUM_NODES-1:0] sample_pending;
  logic [NUM_NODES-1:0] delta_pending;

  assign sample_ready = ~|sample_pending;
  assign delta_ready  = ~|delta_pending;
  assign node_sample_valid = sample_pending;
  assign node_delta_valid  = delta_pending;

  always_ff @(posedge clock) begin
    if (reset) begin
      sample_pending <= '0;
    end else if (sample_valid && sample_ready) begin
      sample_pending <= '1;
    end else begin
      sample_pending <= sample_pending & ~node_sample_ready;
    end
  end

  always_ff @(posedge clock) begin
    if (sample_valid && sample_ready) begin
      node_sample_data <= sample_data;
    end
  end

  // Each node gets its own element of the delta vector
  always_ff @(posedge clock) begin
    if (reset) begin
      delta_pending <= '0;
    end else if (delta_valid && delta_ready) begin
      delta_pending <= '1;
    end else begin
      delta_pending <= delta_pending & ~node_delta_ready;
    end
  end

  always_ff @(posedge clock) begin
    if (delta_valid && delta_ready) begin
      node_delta_data <= delta_data;
    end
  end

endmodule

/* design/layer_gather.sv */
`timescale 1ns/1ps

module layer_gather #(
  parameter int NUM_INPUTS = 2,
  parameter int NUM_NODES  = 1
) (
  input  logic                                                  clock,
  input  logic                                                  reset,

  input  logic [NUM_NODES-1:0]                                  node_result_valid,
  input  nn_format_pkg::act_t [NUM_NODES-1:0]                   node_result_data,
  output logic [NUM_NODES-1:0]                                  node_result_ready,

  input  logic [NUM_NODES-1:0]                                  node_error_valid,
  input  nn_format_pkg::grad_t [NUM_NODES-1:0][NUM_INPUTS-1:0]  node_error_data,
  output logic [NUM_NODES-1:0]                                  node_error_ready,

  output logic                                                  result_valid,
  output nn_format_pkg::act_t [NUM_NODES-1:0]                   result_data,
  input  logic                                                  result_ready,

  output logic                                                  error_valid,
  output nn_format_pkg::grad_t [NUM_INPUTS-1:0]                 error_data,
  input  logic                                                  error_ready
);
  import nn_format_pkg::*;

  // Wide enough that the running sum never wraps
  localparam int SUM_BITS = $bits(grad_t) + $clog2(NUM_NODES + 1);
  typedef logic signed [SUM_BITS-1:0] sum_t;

  localparam sum_t GRAD_MAX = sum_t'(2 ** ($bits(grad_t) - 1) - 1);
  localparam sum_t GRAD_MIN = -sum_t'(2 ** ($bits(grad_t) - 1));

  logic [NUM_NODES-1:0] result_full;
  logic [NUM_NODES-1:0] error_mask;
  logic [NUM_NODES-1:0] result_take;
  logic [NUM_NODES-1:0] error_take;

  sum_t error_sum [NUM_INPUTS];
  sum_t sum_next  [NUM_INPUTS];

  function automatic grad_t saturate(sum_t value);
    if (value > GRAD_MAX) begin
      return GRAD_MAX[$bits(grad_t)-1:0];
    end
    if (value < GRAD_MIN) begin
      return GRAD_MIN[$bits(grad_t)-1:0];
    end
    return value[$bits(grad_t)-1:0];
  endfunction

  assign node_result_ready = ~result_full;
  assign node_error_ready  = ~error_mask;
  assign result_take = node_result_valid & node_result_ready;
  assign error_take  = node_error_valid & node_error_ready;
  assign result_valid = &result_full;
  assign error_valid  = &error_mask;

  always_ff @(posedge clock) begin
    if (reset) begin
      result_full <= '0;
    end else if (result_valid && result_ready) begin
      result_full <= '0;
    end else begin
      result_full <= result_full | result_take;
    end
  end

  always_ff @(posedge clock) begin
    for (int n = 0; n < NUM_NODES; n++) begin
      if (result_take[n]) begin
        result_data[n] <= node_result_data[n];
      end
    end
  end

  // Several nodes may arrive in the same cycle
  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      sum_next[i] = error_sum[i];
      for (int n = 0; n < NUM_NODES; n++) begin
        if (error_take[n]) begin
          sum_next[i] = sum_next[i] + sum_t'(node_error_data[n][i]);
        end
      end
      error_data[i] = saturate(error_sum[i]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset || (error_valid && error_ready)) begin
      error_mask <= '0;
      for (int i = 0; i < NUM_INPUTS; i++) begin
        error_sum[i] <= '0;
      end
    end else begin
      error_mask <= error_mask | error_take;
      for (int i = 0; i < NUM_INPUTS; i++) begin
        error_sum[i] <= sum_next[i];
      end
    end
  end

endmodule

/* design/logistic_table.sv */
`timescale 1ns/1ps

module logistic_table (
  input  logic                                    clock,
  input  logic signed [nn_layer_pkg::TABLE_BITS-1:0] index_a,
  output nn_format_pkg::act_t                     activation,
  input  logic signed [nn_layer_pkg::TABLE_BITS-1:0] index_b,
  output nn_format_pkg::standard_t                derivative
);
  import nn_format_pkg::*;
  import nn_layer_pkg::*;

  localparam int ACT_MAX = 2 ** FRAC_BITS - 1;

  act_t      act_table   [2**TABLE_BITS];
  standard_t deriv_table [2**TABLE_BITS];

  function automatic real logistic(int value);
    return 1.0 / (1.0 + $exp(-6.0 * $itor(value) / (2.0 ** FRAC_BITS)));
  endfunction

  // Entries are stored at the two's complement image of the index
  initial begin
    real level;
    int  scaled;
    for (int i = -(2 ** (TABLE_BITS - 1)); i < 2 ** (TABLE_BITS - 1); i++) begin
      level = logistic(i);
      scaled = $rtoi(level * (2.0 ** FRAC_BITS));
      // Far positive entries round up to 1.0
      if (scaled > ACT_MAX) begin
        scaled = ACT_MAX;
      end
      act_table[i[TABLE_BITS-1:0]] = act_t'(scaled);
      deriv_table[i[TABLE_BITS-1:0]] =
        standard_t'($rtoi(level * (1.0 - level) * (2.0 ** FRAC_BITS)));
    end
  end

  always_ff @(posedge clock) begin
    activation <= act_table[$unsigned(index_a)];
    derivative <= deriv_table[$unsigned(index_b)];
  end

endmodule

/* design/neuron_node.sv */
`timescale 1ns/1ps

module neuron_node #(
  parameter int NUM_INPUTS  = 2,
  parameter int LEARN_SHIFT = 2
) (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   train,

  input  logic                                   sample_valid,
  input  nn_format_pkg::act_t [NUM_INPUTS-1:0]   sample_data,
  output logic                                   sample_ready,

  output logic                                   result_valid,
  output nn_format_pkg::act_t                    result_data,
  input  logic                                   result_ready,

  input  logic                                   delta_valid,
  input  nn_format_pkg::grad_t                   delta_data,
  output logic                                   delta_ready,

  output logic                                   error_valid,
  output nn_format_pkg::grad_t [NUM_INPUTS-1:0]  error_data,
  input  logic                                   error_ready
);
  import nn_format_pkg::*;
  import nn_layer_pkg::*;

  localparam int PRODUCT_BITS = 2 * $bits(extended_t);
  typedef logic signed [PRODUCT_BITS-1:0] product_t;
  typedef logic [$clog2(NUM_INPUTS)-1:0] count_t;

  localparam count_t    LAST      = count_t'(NUM_INPUTS - 1);
  localparam extended_t INDEX_MAX = extended_t'(2 ** (TABLE_BITS - 1) - 1);
  localparam extended_t INDEX_MIN = -extended_t'(2 ** (TABLE_BITS - 1));

  typedef enum logic [2:0] {RDY, MUL, MAC, ACC, FWD, DEL, BWD} state_t;
  state_t state;

  standard_t operand [NUM_INPUTS];
  extended_t weight  [NUM_INPUTS];
  extended_t bias;
  extended_t summand;
  extended_t accumulator;
  extended_t delta;
  extended_t lookup_sum;
  count_t    counter;

  product_t product;
  product_t scaled_grad;
  product_t error_product  [NUM_INPUTS];
  product_t update_product [NUM_INPUTS];

  logic signed [TABLE_BITS-1:0] index_a;
  logic signed [TABLE_BITS-1:0] index_b;
  act_t      activation;
  standard_t derivative;

  // Output register is empty or being emptied this cycle
  logic fwd_free;
  logic bwd_free;

  function automatic logic signed [TABLE_BITS-1:0] saturate_index(extended_t value);
    if (value > INDEX_MAX) begin
      return INDEX_MAX[TABLE_BITS-1:0];
    end
    if (value < INDEX_MIN) begin
      return INDEX_MIN[TABLE_BITS-1:0];
    end
    return value[TABLE_BITS-1:0];
  endfunction

  assign sample_ready = state == RDY;
  assign delta_ready  = state == DEL;
  assign fwd_free = !result_valid || result_ready;
  assign bwd_free = !error_valid || error_ready;

  // Forward lookup starts during ACC so the activation is ready in FWD
  assign lookup_sum = (state == ACC) ? accumulator + summand : accumulator;
  assign index_a = saturate_index(lookup_sum);
  assign index_b = saturate_index(accumulator);

  logistic_table u_table (
    .clock      (clock),
    .index_a    (index_a),
    .activation (activation),
    .index_b    (index_b),
    .derivative (derivative)
  );

  // Single multiplier walked over the operands by the counter
  assign product = weight[counter] * operand[counter];
  assign scaled_grad = delta_data * derivative;

  always_comb begin
    for (int i = 0; i < NUM_INPUTS; i++) begin
      error_product[i] = weight[i] * delta;
      update_product[i] = delta * operand[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      counter <= '0;
    end else if (state == MUL || state == MAC) begin
      counter <= (counter == LAST) ? '0 : counter + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (state == MUL || state == MAC) begin
      summand <= extended_t'(product >>> FRAC_BITS);
    end
  end

  // Held until the next sample so the derivative lookup stays valid
  always_ff @(posedge clock) begin
    if (reset) begin
      accumulator <= '0;
    end else if (sample_valid && sample_ready) begin
      accumulator <= bias;
    end else if (state == MAC || state == ACC) begin
      accumulator <= accumulator + summand;
    end
  end

  always_ff @(posedge clock) begin
    if (sample_valid && sample_ready) begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        operand[i] <= standard_t'({1'b0, sample_data[i]});
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (state == FWD && fwd_free) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (state == FWD && fwd_free) begin
      result_data <= activation;
    end
  end

  always_ff @(posedge clock) begin
    if (delta_valid && delta_ready) begin
      delta <= extended_t'(scaled_grad >>> FRAC_BITS);
    end
  end

  // Errors use the weights from before this update
  always_ff @(posedge clock) begin
    if (state == BWD && bwd_free) begin
      for (int i = 0; i < NUM_INPUTS; i++) begin
        error_data[i] <= grad_t'(error_product[i] >>> FRAC_BITS);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      bias <= '0;
      for (int i = 0; i < NUM_INPUTS; i++) begin
        weight[i] <= '0;
      end
    end else if (state == BWD && bwd_free) begin
      bias <= bias + (delta >>> LEARN_SHIFT);
      for (int i = 0; i < NUM_INPUTS; i++) begin
        weight[i] <= weight[i] + extended_t'(update_product[i] >>> (LEARN_SHIFT + FRAC_BITS));
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      error_valid <= 1'b0;
    end else if (state == BWD && bwd_free) begin
      error_valid <= 1'b1;
    end else if (error_ready) begin
      error_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= RDY;
    end else begin
      case (state)
        RDY: begin
          if (sample_valid) begin
            state <= MUL;
          end
        end
        MUL: state <= MAC;
        MAC: begin
          if (counter == LAST) begin
            state <= ACC;
          end
        end
        ACC: state <= FWD;
        // Train is sampled here to choose the backward pass
        FWD: begin
          if (fwd_free) begin
            state <= train ? DEL : RDY;
          end
        end
        DEL: begin
          if (delta_valid) begin
            state <= BWD;
          end
        end
        BWD: begin
          if (bwd_free) begin
            state <= RDY;
          end
        end
        default: state <= RDY;
      endcase
    end
  end

endmodule

/* design/nn_format_pkg.sv */
package nn_format_pkg;

  // All fixed-point values carry the same number of fraction bits
  localparam int FRAC_BITS = 8;

  // Activation or input value, fraction only
  typedef logic [FRAC_BITS-1:0] act_t;

  // Signed operand, an act_t widened with a zero sign bit
  typedef logic signed [FRAC_BITS:0] standard_t;

  // Weight, bias, accumulator and delta
  typedef logic signed [2*(FRAC_BITS+1)-1:0] extended_t;

  // Incoming delta and outgoing error
  typedef logic signed [2*FRAC_BITS-1:0] grad_t;

endpackage

/* design/nn_layer_pkg.sv */
package nn_layer_pkg;

  // Default layer shape
  localparam int DEFAULT_INPUTS = 4;
  localparam int DEFAULT_NODES = 3;

  // Right shift applied to weight and bias updates
  localparam int DEFAULT_LEARN_SHIFT = 2;

  // Activation table index width, about [-8, 8) in fixed point
  localparam int TABLE_BITS = 12;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the dense layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module dense_layer_tb -f verilog.f -o dense_layer_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dense_layer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* test/dense_layer_checker.sv */
`timescale 1ns/1ps

module dense_layer_checker #(
  parameter int NUM_INPUTS = 2,
  parameter int NUM_NODES  = 1
) (
  input logic                                  clock,
  input logic                                  reset,
  input logic                                  sample_valid,
  input nn_format_pkg::act_t [NUM_INPUTS-1:0]  sample_data,
  input logic                                  sample_ready,
  input logic                                  result_valid,
  input nn_format_pkg::act_t [NUM_NODES-1:0]   result_data,
  input logic                                  result_ready,
  input logic                                  delta_valid,
  input nn_format_pkg::grad_t [NUM_NODES-1:0]  delta_data,
  input logic                                  delta_ready,
  input logic                                  error_valid,
  input nn_format_pkg::grad_t [NUM_INPUTS-1:0] error_data,
  input logic                                  error_ready
);

  // A stalled channel keeps valid and data until the transfer
  sample_hold: assert property (@(posedge clock) disable iff (reset)
    sample_valid && !sample_ready |=> sample_valid && $stable(sample_data))
    else $error("sample_valid dropped or sample_data changed while stalled");

  result_hold: assert property (@(posedge clock) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else $error("result_valid dropped or result_data changed while stalled");

  delta_hold: assert property (@(posedge clock) disable iff (reset)
    delta_valid && !delta_ready |=> delta_valid && $stable(delta_data))
    else $error("delta_valid dropped or delta_data changed while stalled");

  error_hold: assert property (@(posedge clock) disable iff (reset)
    error_valid && !error_ready |=> error_valid && $stable(error_data))
    else $error("error_valid dropped or error_data changed while stalled");

  input_quiet: assert property (@(posedge clock)
    reset |-> !sample_valid && !delta_valid)
    else $error("Input valid high during reset");

  // Output registers are clear one cycle into reset
  output_quiet: assert property (@(posedge clock)
    reset |=> !result_valid && !error_valid)
    else $error("Output valid high during reset");

endmodule

bind dense_layer dense_layer_checker #(
  .NUM_INPUTS (NUM_INPUTS),
  .NUM_NODES  (NUM_NODES)
) u_checker (
  .clock        (clock),
  .reset        (reset),
  .sample_valid (sample_valid),
  .sample_data  (sample_data),
  .sample_ready (sample_ready),
  .result_valid (result_valid),
  .result_data  (result_data),
  .result_ready (result_ready),
  .delta_valid  (delta_valid),
  .delta_data   (delta_data),
  .delta_ready  (delta_ready),
  .error_valid  (error_valid),
  .error_data   (error_data),
  .error_ready  (error_ready)
);

/* test/dense_layer_tb.sv */
`timescale 1ns/1ps

module dense_layer_tb;
  import nn_format_pkg::*;
  import nn_layer_pkg::*;

  localparam int NUM_INPUTS  = DEFAULT_INPUTS;
  localparam int NUM_NODES   = DEFAULT_NODES;
  localparam int LEARN_SHIFT = DEFAULT_LEARN_SHIFT;

  localparam int RESET_CYCLES = 16;
  localparam logic [15:0] SEED = 16'd56972;

  // Transactions per test phase
  localparam int N_RESET = 2;
  localparam int N_INFER = 16;
  localparam int N_TRAIN = 16;
  localparam int N_AFTER = 8;
  localparam int N_STALL = 24;
  localparam int N_MIXED = 24;
  localparam int TOTAL = N_RESET + N_INFER + N_TRAIN + N_AFTER + N_STALL + N_MIXED;
  localparam int CYCLES_PER_TRANSACTION = 200;

  localparam longint INDEX_HIGH = 2 ** (TABLE_BITS - 1) - 1;
  localparam longint INDEX_LOW  = -(2 ** (TABLE_BITS - 1));
  localparam longint GRAD_HIGH  = 2 ** ($bits(grad_t) - 1) - 1;
  localparam longint GRAD_LOW   = -(2 ** ($bits(grad_t) - 1));
  localparam real    UNIT       = real'(2 ** FRAC_BITS);

  typedef act_t  [NUM_INPUTS-1:0] sample_vec_t;
  typedef act_t  [NUM_NODES-1:0]  result_vec_t;
  typedef grad_t [NUM_NODES-1:0]  delta_vec_t;
  typedef grad_t [NUM_INPUTS-1:0] error_vec_t;

  logic        clock;
  logic        reset;
  logic        train;
  logic        sample_valid;
  sample_vec_t sample_data;
  logic        sample_ready;
  logic        result_valid;
  result_vec_t result_data;
  logic        result_ready;
  logic        delta_valid;
  delta_vec_t  delta_data;
  logic        delta_ready;
  logic        error_valid;
  error_vec_t  error_data;
  logic        error_ready;

  // Reference model state
  extended_t model_weight [NUM_NODES][NUM_INPUTS];
  extended_t model_bias   [NUM_NODES];
  int        model_index  [NUM_NODES];

  result_vec_t expected_result [$];
  error_vec_t  expected_error  [$];
  string       result_test     [$];
  string       error_test      [$];

  logic [15:0] drive_state;
  logic [15:0] stall_state;
  logic stall_mode;
  logic gap_mode;

  dense_layer u_dut (
    .clock        (clock),
    .reset        (reset),
    .train        (train),
    .sample_valid (sample_valid),
    .sample_data  (sample_data),
    .sample_ready (sample_ready),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_ready (result_ready),
    .delta_valid  (delta_valid),
    .delta_data   (delta_data),
    .delta_ready  (delta_ready),
    .error_valid  (error_valid),
    .error_data   (error_data),
    .error_ready  (error_ready)
  );

  always #4 clock = ~clock;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] state, input int count,
                           output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      state = lfsr_next(state);
      value = {value[30:0], state[0]};
    end
  endtask

  function automatic longint clamp(longint value, longint low, longint high);
    if (value < low) begin
      return low;
    end
    if (value > high) begin
      return high;
    end
    return value;
  endfunction

  function automatic real logistic_level(int index);
    return 1.0 / (1.0 + $exp(-6.0 * real'(index) / UNIT));
  endfunction

  function automatic result_vec_t model_forward(sample_vec_t sample);
    result_vec_t result;
    extended_t   sum;
    int          level;
    for (int n = 0; n < NUM_NODES; n++) begin
      sum = model_bias[n];
      for (int i = 0; i < NUM_INPUTS; i++) begin
        sum = sum + extended_t'((longint'(model_weight[n][i]) * longint'(sample[i]))
                                >>> FRAC_BITS);
      end
      model_index[n] = int'(clamp(longint'(sum), INDEX_LOW, INDEX_HIGH));
      level = $rtoi(logistic_level(model_index[n]) * UNIT);
      // 1.0 is out of range and stays just below it
      if (level > 2 ** FRAC_BITS - 1) begin
        level = 2 ** FRAC_BITS - 1;
      end
      result[n] = act_t'(level);
    end
    return result;
  endfunction

  function automatic error_vec_t model_backward(delta_vec_t grad, sample_vec_t sample);
    error_vec_t error;
    longint     total [NUM_INPUTS];
    extended_t  delta;
    longint     slope;
    real        level;
    for (int i = 0; i < NUM_INPUTS; i++) begin
      total[i] = 0;
    end
    for (int n = 0; n < NUM_NODES; n++) begin
      level = logistic_level(model_index[n]);
      slope = longint'($rtoi(level * (1.0 - level) * UNIT));
      delta = extended_t'((longint'(grad[n]) * slope) >>> FRAC_BITS);
      for (int i = 0; i < NUM_INPUTS; i++) begin
        // Error is taken from the weight before its update
        total[i] += longint'(grad_t'((longint'(model_weight[n][i]) * longint'(delta))
                                     >>> FRAC_BITS));
        model_weight[n][i] = model_weight[n][i] +
          extended_t'((longint'(delta) * longint'(sample[i])) >>> (LEARN_SHIFT + FRAC_BITS));
      end
      model_bias[n] = model_bias[n] + (delta >>> LEARN_SHIFT);
    end
    for (int i = 0; i < NUM_INPUTS; i++) begin
      error[i] = grad_t'(clamp(total[i], GRAD_LOW, GRAD_HIGH));
    end
    return error;
  endfunction

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic compare_result(string name, result_vec_t expected, result_vec_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  task automatic compare_error(string name, error_vec_t expected, error_vec_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
    end
  endtask

  // Handshakes are sampled at the falling edge ahead of the transfer
  always @(negedge clock) begin
    if (!reset && result_valid && result_ready) begin
      if (expected_result.size() == 0) begin
        stop_with_failure("A result came out with no sample outstanding");
      end else begin
        compare_result(result_test.pop_front(), expected_result.pop_front(), result_data);
      end
    end
    if (!reset && error_valid && error_ready) begin
      if (expected_error.size() == 0) begin
        stop_with_failure("An error vector came out with no delta outstanding");
      end else begin
        compare_error(error_test.pop_front(), expected_error.pop_front(), error_data);
      end
    end
  end

  // Ready lines toggle randomly while stalls are enabled
  initial begin
    logic [31:0] bits;
    result_ready = 1'b0;
    error_ready = 1'b0;
    forever begin
      @(posedge clock);
      #1;
      if (stall_mode) begin
        draw_bits(stall_state, 2, bits);
        result_ready = bits[0];
        error_ready = bits[1];
      end else begin
        result_ready = 1'b1;
        error_ready = 1'b1;
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + TOTAL * CYCLES_PER_TRANSACTION) @(posedge clock);
    stop_with_failure("Timeout: the layer stopped answering");
  end

  task automatic wait_cycles(int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic wait_idle();
    while (expected_result.size() != 0 || expected_error.size() != 0) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic send_sample(sample_vec_t sample);
    sample_valid = 1'b1;
    sample_data = sample;
    while (!sample_ready) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    sample_valid = 1'b0;
  endtask

  task automatic send_delta(delta_vec_t grad);
    delta_valid = 1'b1;
    delta_data = grad;
    while (!delta_ready) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    delta_valid = 1'b0;
  endtask

  task automatic run_transaction(string name, logic do_train, logic expect_midpoint);
    sample_vec_t sample;
    delta_vec_t  grad;
    result_vec_t result;
    logic [31:0] bits;
    // Nodes read train when they finish the forward pass, so change it only when idle
    if (do_train !== train) begin
      wait_idle();
      train = do_train;
    end
    if (gap_mode) begin
      draw_bits(drive_state, 2, bits);
      wait_cycles(int'(bits[1:0]));
    end
    for (int i = 0; i < NUM_INPUTS; i++) begin
      draw_bits(drive_state, FRAC_BITS, bits);
      sample[i] = act_t'(bits);
    end
    result = model_forward(sample);
    if (expect_midpoint) begin
      result = {NUM_NODES{act_t'(128)}};
    end
    expected_result.push_back(result);
    result_test.push_back(name);
    if (do_train) begin
      for (int n = 0; n < NUM_NODES; n++) begin
        draw_bits(drive_state, 12, bits);
        grad[n] = grad_t'($signed(bits[11:0]));
      end
      expected_error.push_back(model_backward(grad, sample));
      error_test.push_back(name);
    end
    send_sample(sample);
    // The delta goes in before the result is taken
    if (do_train) begin
      if (gap_mode) begin
        draw_bits(drive_state, 2, bits);
        wait_cycles(int'(bits[1:0]));
      end
      send_delta(grad);
    end
  endtask

  initial begin
    logic [31:0] bits;
    clock = 1'b0;
    reset = 1'b1;
    train = 1'b0;
    sample_valid = 1'b0;
    sample_data = '0;
    delta_valid = 1'b0;
    delta_data = '0;
    stall_mode = 1'b0;
    gap_mode = 1'b0;
    drive_state = SEED;
    draw_bits(drive_state, 16, bits);
    stall_state = bits[15:0] | 16'h0001;
    for (int n = 0; n < NUM_NODES; n++) begin
      model_bias[n] = '0;
      for (int i = 0; i < NUM_INPUTS; i++) begin
        model_weight[n][i] = '0;
      end
    end

    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;

    for (int k = 0; k < N_RESET; k++) begin
      run_transaction("reset_zero", 1'b0, 1'b1);
    end
    for (int k = 0; k < N_INFER; k++) begin
      run_transaction("inference", 1'b0, 1'b0);
    end
    for (int k = 0; k < N_TRAIN; k++) begin
      run_transaction("training", 1'b1, 1'b0);
    end
    for (int k = 0; k < N_AFTER; k++) begin
      run_transaction("after_training", 1'b0, 1'b0);
    end
    stall_mode = 1'b1;
    gap_mode = 1'b1;
    for (int k = 0; k < N_STALL; k++) begin
      run_transaction("back_pressure", 1'b1, 1'b0);
    end
    for (int k = 0; k < N_MIXED; k++) begin
      draw_bits(drive_state, 1, bits);
      run_transaction("mixed", bits[0], 1'b0);
    end
    wait_idle();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* verilog.f */
design/nn_format_pkg.sv
design/nn_layer_pkg.sv
design/logistic_table.sv
design/neuron_node.sv
design/layer_dispatch.sv
design/layer_gather.sv
design/dense_layer.sv
test/dense_layer_checker.sv
test/dense_layer_tb.sv
